/* include/dx_settings.svh */
//**************************************************************************
// Widths and build options for the decode to execute stage
//**************************************************************************
`ifndef DX_SETTINGS_SVH
`define DX_SETTINGS_SVH

// Data path and pc width
`define DX_WORD_W 32
// Register file address width
`define DX_RF_ADR_W 5
// Major opcode width
`define DX_OPCODE_W 6

// Immediate fields of jump and branch instructions
`define DX_IMM16_W 16
`define DX_IMMJBR_W 10

// Set to 1 when jumps and branches have a delay slot
`define DX_DELAY_SLOT 1

`endif

/* hdl/dx_isa_pkg.sv */
//**************************************************************************
// Instruction set definitions: immediate field union and opcode constants
//**************************************************************************
`include "dx_settings.svh"

package dx_isa_pkg;

   localparam int IMM_FIELD_W = `DX_IMMJBR_W + `DX_IMM16_W;

   // Decode sees the split view, branch logic the signed word offset
   typedef union packed {
      struct packed {
         logic [`DX_IMMJBR_W-1:0] upper;
         logic [`DX_IMM16_W-1:0]  imm16;
      } split;
      logic signed [IMM_FIELD_W-1:0] offset;
   } imm_field_u;

   // Opcode loaded into execute for reset, flush and bubbles
   localparam logic [`DX_OPCODE_W-1:0] OPC_NOP = 6'h05;

   // Set for bf, clear for bnf
   localparam int OPC_COND_BIT = 2;

   // Both bits clear for the unconditional jumps
   localparam logic [`DX_OPCODE_W-1:0] OPC_UNCOND_MASK = 6'b000110;

endpackage

/* hdl/dx_pipe_pkg.sv */
//**************************************************************************
// Pipeline constants: instruction size and pc steps
//**************************************************************************
`include "dx_settings.svh"

package dx_pipe_pkg;

   localparam int INSN_BYTES = 4;

   // Low pc bits that must be zero for an aligned instruction
   localparam int ALIGN_W = $clog2(INSN_BYTES);

   // Return address skips the delay slot when there is one
   localparam logic [`DX_WORD_W-1:0] LINK_STEP =
      (`DX_DELAY_SLOT != 0) ? `DX_WORD_W'(2 * INSN_BYTES) : `DX_WORD_W'(INSN_BYTES);

endpackage

/* hdl/dx_hazard_detect.sv */
//**************************************************************************
// Operand hazard detection for decode to execute
// Bubble strobe and jump register operand readiness
//**************************************************************************
`include "dx_settings.svh"

module dx_hazard_detect (
   input  logic                   padv_i,
   input  logic                   decode_op_mul_i,
   input  logic                   decode_op_jr_i,
   input  logic                   decode_op_rfe_i,
   input  logic [`DX_RF_ADR_W-1:0] decode_rfa_adr_i,
   input  logic [`DX_RF_ADR_W-1:0] decode_rfb_adr_i,
   input  logic                   ctrl_op_lsu_load_i,
   input  logic                   ctrl_op_mfspr_i,
   input  logic                   ctrl_op_mul_i,
   input  logic [`DX_RF_ADR_W-1:0] ctrl_rfd_adr_i,
   input  logic                   exec_op_lsu_load_i,
   input  logic                   exec_op_mfspr_i,
   input  logic                   exec_op_mul_i,
   input  logic                   exec_op_lsu_store_i,
   input  logic                   exec_op_lsu_atomic_i,
   input  logic                   exec_rf_wb_i,
   input  logic [`DX_RF_ADR_W-1:0] exec_rfd_adr_i,
   output logic                   bubble_o,
   output logic                   jr_ready_o
);

   logic ctrl_interlock;
   logic exec_hit_a;
   logic exec_hit_b;
   logic late_hazard;
   logic mul_hazard;

   // Load, mfspr and mul results only exist in ctrl stage
   assign ctrl_interlock = (ctrl_op_lsu_load_i | ctrl_op_mfspr_i | ctrl_op_mul_i) &
                           ((decode_rfa_adr_i == ctrl_rfd_adr_i) |
                            (decode_rfb_adr_i == ctrl_rfd_adr_i));

   assign exec_hit_a = (decode_rfa_adr_i == exec_rfd_adr_i);
   assign exec_hit_b = (decode_rfb_adr_i == exec_rfd_adr_i);

   // Execute stage result that cannot be bypassed back in time
   assign late_hazard = (exec_op_lsu_load_i | exec_op_mfspr_i | exec_op_mul_i) &
                        (exec_hit_a | exec_hit_b);

   // Pipelined multiplier takes its operands straight from decode
   assign mul_hazard = decode_op_mul_i &
                       (ctrl_interlock | exec_rf_wb_i & (exec_hit_a | exec_hit_b));

   // Jump target register must be settled when the jump resolves
   assign jr_ready_o = !(ctrl_interlock | exec_rf_wb_i & exec_hit_b);

   // rfe bubbles to hold fetch while it travels to ctrl
   assign bubble_o = padv_i & (late_hazard |
                               mul_hazard |
                               decode_op_jr_i & !jr_ready_o |
                               exec_op_lsu_store_i & exec_op_lsu_atomic_i |
                               decode_op_rfe_i);

endmodule

/* hdl/dx_branch_resolve.sv */
//**************************************************************************
// Branch resolution in decode
// Taken decision, targets, link value and target alignment check
//**************************************************************************
`include "dx_settings.svh"

module dx_branch_resolve (
   input  logic [`DX_WORD_W-1:0]   pc_decode_i,
   input  dx_isa_pkg::imm_field_u  decode_imm_i,
   input  logic                    decode_op_jbr_i,
   input  logic                    decode_op_jr_i,
   input  logic                    decode_op_bf_i,
   input  logic                    decode_op_bnf_i,
   input  logic [`DX_OPCODE_W-1:0] decode_opc_insn_i,
   input  logic                    predicted_flag_i,
   input  logic                    jr_ready_i,
   input  logic                    pipeline_flush_i,
   input  logic [`DX_WORD_W-1:0]   decode_rfb_i,
   input  logic [`DX_WORD_W-1:0]   execute_rfb_i,
   input  logic                    exec_bubble_i,
   input  logic                    exec_op_jr_i,
   output logic                    decode_branch_o,
   output logic [`DX_WORD_W-1:0]   decode_branch_target_o,
   output logic [`DX_WORD_W-1:0]   mispredict_target_o,
   output logic [`DX_WORD_W-1:0]   link_result_o,
   output logic                    except_align_o
);

   logic                         uncond_jump;
   logic                         branch_to_imm;
   logic                         branch_to_reg;
   logic signed [`DX_WORD_W-1:0] offset_ext;
   logic [`DX_WORD_W-1:0]        imm_target;
   logic [`DX_WORD_W-1:0]        reg_target;

   assign uncond_jump = !(|(decode_opc_insn_i & dx_isa_pkg::OPC_UNCOND_MASK));

   // Conditional branches follow the predicted flag
   assign branch_to_imm = decode_op_jbr_i &
                          (uncond_jump |
                           (decode_opc_insn_i[dx_isa_pkg::OPC_COND_BIT] == predicted_flag_i));

   // Word offset scaled to bytes
   assign offset_ext = `DX_WORD_W'(decode_imm_i.offset);
   assign imm_target = pc_decode_i + (offset_ext <<< dx_pipe_pkg::ALIGN_W);

   assign branch_to_reg = decode_op_jr_i & jr_ready_i;

   // After a bubble the operand is only valid in the execute stage result
   assign reg_target = (exec_bubble_i | exec_op_jr_i) ? execute_rfb_i : decode_rfb_i;

   assign decode_branch_o = (branch_to_imm | branch_to_reg) & !pipeline_flush_i;
   assign decode_branch_target_o = branch_to_imm ? imm_target : reg_target;

   assign link_result_o = pc_decode_i + dx_pipe_pkg::LINK_STEP;

   // Where to go if the prediction turns out wrong in ctrl
   assign mispredict_target_o = (decode_op_bf_i & !predicted_flag_i |
                                 decode_op_bnf_i & predicted_flag_i) ?
                                imm_target : link_result_o;

   assign except_align_o = decode_branch_o &
                           (|decode_branch_target_o[dx_pipe_pkg::ALIGN_W-1:0]);

endmodule

/* hdl/dx_execute_reg.sv */
//**************************************************************************
// Execute stage registers
// Op flags, opcode, pc, link value and exceptions with flush and bubble
//**************************************************************************
`include "dx_settings.svh"

module dx_execute_reg (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   input  logic                     bubble_i,
   input  logic                     decode_op_alu_i, decode_op_mul_i, decode_op_lsu_load_i,
   input  logic                     decode_op_lsu_store_i, decode_op_lsu_atomic_i,
   input  logic                     decode_op_mfspr_i, decode_op_jr_i, decode_op_jal_i,
   input  logic                     decode_op_brcond_i, decode_op_bf_i, decode_op_bnf_i,
   input  logic                     decode_op_rfe_i, decode_rf_wb_i,
   input  logic [`DX_RF_ADR_W-1:0]  decode_rfd_adr_i,
   input  logic [`DX_OPCODE_W-1:0]  decode_opc_insn_i,
   input  logic [`DX_WORD_W-1:0]    pc_decode_i,
   input  logic                     predicted_flag_i,
   input  logic [`DX_WORD_W-1:0]    mispredict_target_i,
   input  logic [`DX_WORD_W-1:0]    link_result_i,
   input  logic                     except_illegal_i,
   input  logic                     except_align_i,
   output logic                     execute_op_alu_o, execute_op_mul_o, execute_op_lsu_load_o,
   output logic                     execute_op_lsu_store_o, execute_op_lsu_atomic_o,
   output logic                     execute_op_mfspr_o, execute_op_jr_o, execute_op_jal_o,
   output logic                     execute_op_brcond_o, execute_op_bf_o, execute_op_bnf_o,
   output logic                     execute_op_rfe_o, execute_rf_wb_o,
   output logic [`DX_RF_ADR_W-1:0]  execute_rfd_adr_o,
   output logic [`DX_OPCODE_W-1:0]  execute_opc_insn_o,
   output logic [`DX_WORD_W-1:0]    pc_execute_o,
   output logic                     execute_predicted_flag_o,
   output logic [`DX_WORD_W-1:0]    execute_mispredict_target_o,
   output logic [`DX_WORD_W-1:0]    execute_jal_result_o,
   output logic                     execute_except_illegal_o,
   output logic                     execute_except_ibus_align_o,
   output logic                     decode_valid_o,
   output logic                     execute_bubble_o
);

   localparam int N_FLAGS = 12;

   logic [N_FLAGS-1:0] flags_d;
   logic [N_FLAGS-1:0] flags_q;

   // Flags that a bubble turns into a no-op
   assign flags_d = {decode_op_alu_i, decode_op_mul_i, decode_op_lsu_load_i,
                     decode_op_lsu_store_i, decode_op_lsu_atomic_i, decode_op_mfspr_i,
                     decode_op_jr_i, decode_op_jal_i, decode_op_brcond_i,
                     decode_op_bf_i, decode_op_bnf_i, decode_rf_wb_i};

   assign {execute_op_alu_o, execute_op_mul_o, execute_op_lsu_load_o,
           execute_op_lsu_store_o, execute_op_lsu_atomic_o, execute_op_mfspr_o,
           execute_op_jr_o, execute_op_jal_o, execute_op_brcond_o,
           execute_op_bf_o, execute_op_bnf_o, execute_rf_wb_o} = flags_q;

   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         flags_q            <= '0;
         execute_opc_insn_o <= dx_isa_pkg::OPC_NOP;
      end else if (padv_i && bubble_i) begin
         flags_q            <= '0;
         execute_opc_insn_o <= dx_isa_pkg::OPC_NOP;
      end else if (padv_i) begin
         flags_q            <= flags_d;
         execute_opc_insn_o <= decode_opc_insn_i;
      end
   end

   // rfe keeps going through its own bubbles so it reaches ctrl,
   // the flush it raises there clears it again
   always_ff @(posedge clk) begin
      if (rst || pipeline_flush_i) begin
         execute_op_rfe_o <= 1'b0;
         execute_bubble_o <= 1'b0;
      end else if (padv_i) begin
         execute_op_rfe_o <= decode_op_rfe_i;
         execute_bubble_o <= bubble_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_valid_o              <= 1'b0;
         execute_except_illegal_o    <= 1'b0;
         execute_except_ibus_align_o <= 1'b0;
      end else begin
         decode_valid_o <= padv_i;
         if (padv_i) begin
            execute_except_illegal_o    <= except_illegal_i;
            execute_except_ibus_align_o <= except_align_i;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (padv_i) begin
         pc_execute_o         <= pc_decode_i;
         execute_rfd_adr_o    <= decode_rfd_adr_i;
         execute_jal_result_o <= link_result_i;
      end
      // Prediction state is only meaningful for conditional branches
      if (padv_i && decode_op_brcond_i) begin
         execute_mispredict_target_o <= mispredict_target_i;
         execute_predicted_flag_o    <= predicted_flag_i;
      end
   end

endmodule

/* hdl/decode_execute.sv */
//**************************************************************************
// Decode to execute stage top
// Hazard detection, branch resolution and execute stage registers
//**************************************************************************
`include "dx_settings.svh"

module decode_execute (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     pipeline_flush_i,
   input  logic [`DX_WORD_W-1:0]    pc_decode_i,
   input  logic [`DX_IMM16_W-1:0]   decode_imm16_i,
   input  logic [`DX_IMMJBR_W-1:0]  decode_immjbr_upper_i,
   input  logic [`DX_WORD_W-1:0]    decode_rfb_i,
   input  logic [`DX_WORD_W-1:0]    execute_rfb_i,
   input  logic                     predicted_flag_i,
   input  logic                     decode_op_alu_i, decode_op_mul_i, decode_op_lsu_load_i,
   input  logic                     decode_op_lsu_store_i, decode_op_lsu_atomic_i,
   input  logic                     decode_op_mfspr_i, decode_op_jbr_i, decode_op_jr_i,
   input  logic                     decode_op_jal_i, decode_op_brcond_i, decode_op_bf_i,
   input  logic                     decode_op_bnf_i, decode_op_rfe_i, decode_rf_wb_i,
   input  logic [`DX_RF_ADR_W-1:0]  decode_rfd_adr_i,
   input  logic [`DX_RF_ADR_W-1:0]  decode_rfa_adr_i,
   input  logic [`DX_RF_ADR_W-1:0]  decode_rfb_adr_i,
   input  logic [`DX_OPCODE_W-1:0]  decode_opc_insn_i,
   input  logic                     decode_except_illegal_i,
   input  logic                     ctrl_op_lsu_load_i, ctrl_op_mfspr_i, ctrl_op_mul_i,
   input  logic [`DX_RF_ADR_W-1:0]  ctrl_rfd_adr_i,
   output logic                     decode_bubble_o,
   output logic                     decode_branch_o,
   output logic [`DX_WORD_W-1:0]    decode_branch_target_o,
   output logic                     execute_op_alu_o, execute_op_mul_o, execute_op_lsu_load_o,
   output logic                     execute_op_lsu_store_o, execute_op_lsu_atomic_o,
   output logic                     execute_op_mfspr_o, execute_op_jr_o, execute_op_jal_o,
   output logic                     execute_op_brcond_o, execute_op_bf_o, execute_op_bnf_o,
   output logic                     execute_op_rfe_o, execute_rf_wb_o,
   output logic [`DX_RF_ADR_W-1:0]  execute_rfd_adr_o,
   output logic [`DX_OPCODE_W-1:0]  execute_opc_insn_o,
   output logic [`DX_WORD_W-1:0]    pc_execute_o,
   output logic                     execute_predicted_flag_o,
   output logic [`DX_WORD_W-1:0]    execute_mispredict_target_o,
   output logic [`DX_WORD_W-1:0]    execute_jal_result_o,
   output logic                     execute_except_illegal_o,
   output logic                     execute_except_ibus_align_o,
   output logic                     decode_valid_o,
   output logic                     execute_bubble_o
);

   dx_isa_pkg::imm_field_u  decode_imm;
   logic                    jr_ready;
   logic [`DX_WORD_W-1:0]   mispredict_target;
   logic [`DX_WORD_W-1:0]   link_result;
   logic                    except_align;

   // Decode delivers the immediate in its two halves
   assign decode_imm.split = '{upper: decode_immjbr_upper_i, imm16: decode_imm16_i};

   dx_hazard_detect i_hazard (
      .padv_i               (padv_i),
      .decode_op_mul_i      (decode_op_mul_i),
      .decode_op_jr_i       (decode_op_jr_i),
      .decode_op_rfe_i      (decode_op_rfe_i),
      .decode_rfa_adr_i     (decode_rfa_adr_i),
      .decode_rfb_adr_i     (decode_rfb_adr_i),
      .ctrl_op_lsu_load_i   (ctrl_op_lsu_load_i),
      .ctrl_op_mfspr_i      (ctrl_op_mfspr_i),
      .ctrl_op_mul_i        (ctrl_op_mul_i),
      .ctrl_rfd_adr_i       (ctrl_rfd_adr_i),
      .exec_op_lsu_load_i   (execute_op_lsu_load_o),
      .exec_op_mfspr_i      (execute_op_mfspr_o),
      .exec_op_mul_i        (execute_op_mul_o),
      .exec_op_lsu_store_i  (execute_op_lsu_store_o),
      .exec_op_lsu_atomic_i (execute_op_lsu_atomic_o),
      .exec_rf_wb_i         (execute_rf_wb_o),
      .exec_rfd_adr_i       (execute_rfd_adr_o),
      .bubble_o             (decode_bubble_o),
      .jr_ready_o           (jr_ready)
   );

   dx_branch_resolve i_branch (
      .pc_decode_i            (pc_decode_i),
      .decode_imm_i           (decode_imm),
      .decode_op_jbr_i        (decode_op_jbr_i),
      .decode_op_jr_i         (decode_op_jr_i),
      .decode_op_bf_i         (decode_op_bf_i),
      .decode_op_bnf_i        (decode_op_bnf_i),
      .decode_opc_insn_i      (decode_opc_insn_i),
      .predicted_flag_i       (predicted_flag_i),
      .jr_ready_i             (jr_ready),
      .pipeline_flush_i       (pipeline_flush_i),
      .decode_rfb_i           (decode_rfb_i),
      .execute_rfb_i          (execute_rfb_i),
      .exec_bubble_i          (execute_bubble_o),
      .exec_op_jr_i           (execute_op_jr_o),
      .decode_branch_o        (decode_branch_o),
      .decode_branch_target_o (decode_branch_target_o),
      .mispredict_target_o    (mispredict_target),
      .link_result_o          (link_result),
      .except_align_o         (except_align)
   );

   // Remaining ports share their names with the top level
   dx_execute_reg i_exec_reg (
      .*,
      .bubble_i            (decode_bubble_o),
      .mispredict_target_i (mispredict_target),
      .link_result_i       (link_result),
      .except_illegal_i    (decode_except_illegal_i),
      .except_align_i      (except_align)
   );

endmodule

/* dv/decode_execute_tb.sv */
//**************************************************************************
// Testbench for the decode to execute stage
// Vector file driver, typed compare tasks and watchdog
//**************************************************************************
`include "dx_settings.svh"

module decode_execute_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam string VEC_FILE = "dv/dx_testdata.txt";

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    padv_i, pipeline_flush_i, predicted_flag_i, decode_except_illegal_i;
   logic [`DX_WORD_W-1:0]   pc_decode_i, decode_rfb_i, execute_rfb_i;
   logic [`DX_IMM16_W-1:0]  decode_imm16_i;
   logic [`DX_IMMJBR_W-1:0] decode_immjbr_upper_i;
   logic                    decode_op_alu_i, decode_op_mul_i, decode_op_lsu_load_i;
   logic                    decode_op_lsu_store_i, decode_op_lsu_atomic_i, decode_op_mfspr_i;
   logic                    decode_op_jbr_i, decode_op_jr_i, decode_op_jal_i;
   logic                    decode_op_brcond_i, decode_op_bf_i, decode_op_bnf_i;
   logic                    decode_op_rfe_i, decode_rf_wb_i;
   logic [`DX_RF_ADR_W-1:0] decode_rfd_adr_i, decode_rfa_adr_i, decode_rfb_adr_i;
   logic [`DX_RF_ADR_W-1:0] ctrl_rfd_adr_i;
   logic [`DX_OPCODE_W-1:0] decode_opc_insn_i;
   logic                    ctrl_op_lsu_load_i, ctrl_op_mfspr_i, ctrl_op_mul_i;

   logic                    decode_bubble_o, decode_branch_o;
   logic [`DX_WORD_W-1:0]   decode_branch_target_o;
   logic                    execute_op_alu_o, execute_op_mul_o, execute_op_lsu_load_o;
   logic                    execute_op_lsu_store_o, execute_op_lsu_atomic_o, execute_op_mfspr_o;
   logic                    execute_op_jr_o, execute_op_jal_o, execute_op_brcond_o;
   logic                    execute_op_bf_o, execute_op_bnf_o, execute_op_rfe_o, execute_rf_wb_o;
   logic [`DX_RF_ADR_W-1:0] execute_rfd_adr_o;
   logic [`DX_OPCODE_W-1:0] execute_opc_insn_o;
   logic [`DX_WORD_W-1:0]   pc_execute_o, execute_mispredict_target_o, execute_jal_result_o;
   logic                    execute_predicted_flag_o, execute_except_illegal_o;
   logic                    execute_except_ibus_align_o, decode_valid_o, execute_bubble_o;

   // Vector fields that do not map straight onto a DUT input
   logic [13:0]             in_flags;
   logic [2:0]              in_ctrl;
   logic [25:0]             in_imm;
   logic [`DX_WORD_W-1:0]   in_rfb_d, in_rfb_e, exp_target, exp_pc, exp_jal, exp_mis;
   logic [12:0]             exp_xflags;
   logic                    exp_bubble, exp_branch, exp_xbub, exp_valid, exp_pf, exp_il, exp_al;
   logic [`DX_OPCODE_W-1:0] exp_opc;
   logic [`DX_RF_ADR_W-1:0] exp_rfd;
   logic [1:0]              exp_chk;

   string                   vectors[$];
   int unsigned             vec_count = 0;
   // Bit k of the execute flag vector
   string flag_names [13] = '{"execute_rf_wb_o", "execute_op_rfe_o", "execute_op_bnf_o",
                              "execute_op_bf_o", "execute_op_brcond_o", "execute_op_jal_o",
                              "execute_op_jr_o", "execute_op_mfspr_o", "execute_op_lsu_atomic_o",
                              "execute_op_lsu_store_o", "execute_op_lsu_load_o",
                              "execute_op_mul_o", "execute_op_alu_o"};

   decode_execute i_decode_execute (.*);

   always #5 clk = ~clk;

   task automatic stop_run(string reason);
      $display("** FAIL **");
      $fatal(1, "%s", reason);
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         stop_run("output mismatch");
      end
   endtask

   task automatic check_word(string name, logic [`DX_WORD_W-1:0] got,
                             logic [`DX_WORD_W-1:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run("output mismatch");
      end
   endtask

   task automatic check_opc(string name, logic [`DX_OPCODE_W-1:0] got,
                            logic [`DX_OPCODE_W-1:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run("output mismatch");
      end
   endtask

   // Inputs, combinational results, then registered results of the next cycle
   task automatic parse_vector(string text, output int n_fields);
      n_fields = $sscanf(text,
         "%b %b %b %h %h %h %h %h %h %h %h %b %b %b %h %b %b %h %b %b %b %h %h %h %h %h %b %b %b %h",
                         padv_i, pipeline_flush_i, in_flags,
                         decode_rfd_adr_i, decode_rfa_adr_i, decode_rfb_adr_i,
                         decode_opc_insn_i, pc_decode_i, in_imm, in_rfb_d, in_rfb_e,
                         predicted_flag_i, decode_except_illegal_i, in_ctrl, ctrl_rfd_adr_i,
                         exp_bubble, exp_branch, exp_target,
                         exp_xflags, exp_xbub, exp_valid, exp_opc, exp_rfd, exp_pc,
                         exp_jal, exp_mis, exp_pf, exp_il, exp_al, exp_chk);
   endtask

   task automatic apply_decode_flags(logic [13:0] flags);
      {decode_op_alu_i, decode_op_mul_i, decode_op_lsu_load_i, decode_op_lsu_store_i,
       decode_op_lsu_atomic_i, decode_op_mfspr_i, decode_op_jbr_i, decode_op_jr_i,
       decode_op_jal_i, decode_op_brcond_i, decode_op_bf_i, decode_op_bnf_i,
       decode_op_rfe_i, decode_rf_wb_i} = flags;
   endtask

   task automatic check_combinational();
      check_flag("decode_bubble_o", decode_bubble_o, exp_bubble);
      check_flag("decode_branch_o", decode_branch_o, exp_branch);
      if (exp_branch) begin
         check_word("decode_branch_target_o", decode_branch_target_o, exp_target);
      end
   endtask

   task automatic check_registered();
      logic [12:0] got_flags;
      got_flags = {execute_op_alu_o, execute_op_mul_o, execute_op_lsu_load_o,
                   execute_op_lsu_store_o, execute_op_lsu_atomic_o, execute_op_mfspr_o,
                   execute_op_jr_o, execute_op_jal_o, execute_op_brcond_o,
                   execute_op_bf_o, execute_op_bnf_o, execute_op_rfe_o, execute_rf_wb_o};
      for (int k = 0; k < 13; k++) begin
         check_flag(flag_names[k], got_flags[k], exp_xflags[k]);
      end
      check_flag("execute_bubble_o", execute_bubble_o, exp_xbub);
      check_flag("decode_valid_o", decode_valid_o, exp_valid);
      check_opc("execute_opc_insn_o", execute_opc_insn_o, exp_opc);
      check_flag("execute_except_illegal_o", execute_except_illegal_o, exp_il);
      check_flag("execute_except_ibus_align_o", execute_except_ibus_align_o, exp_al);
      // Unreset registers are compared only once the vectors have loaded them
      if (exp_chk[0]) begin
         check_word("execute_rfd_adr_o", `DX_WORD_W'(execute_rfd_adr_o), `DX_WORD_W'(exp_rfd));
         check_word("pc_execute_o", pc_execute_o, exp_pc);
         check_word("execute_jal_result_o", execute_jal_result_o, exp_jal);
      end
      if (exp_chk[1]) begin
         check_word("execute_mispredict_target_o", execute_mispredict_target_o, exp_mis);
         check_flag("execute_predicted_flag_o", execute_predicted_flag_o, exp_pf);
      end
   endtask

   initial begin
      int    fd;
      int    n_fields;
      string line;
      void'($urandom(55748));
      rst = 1'b1;
      padv_i = 1'b0;
      pipeline_flush_i = 1'b0;
      predicted_flag_i = 1'b0;
      decode_except_illegal_i = 1'b0;
      pc_decode_i = '0;
      decode_rfb_i = '0;
      execute_rfb_i = '0;
      decode_imm16_i = '0;
      decode_immjbr_upper_i = '0;
      apply_decode_flags('0);
      decode_rfd_adr_i = '0;
      decode_rfa_adr_i = '0;
      decode_rfb_adr_i = '0;
      ctrl_rfd_adr_i = '0;
      decode_opc_insn_i = '0;
      {ctrl_op_lsu_load_i, ctrl_op_mfspr_i, ctrl_op_mul_i} = '0;

      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         stop_run("could not open the vector file dv/dx_testdata.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line[0] != "#") begin
            vectors.push_back(line);
         end
      end
      $fclose(fd);
      if (vectors.size() == 0) begin
         stop_run("the vector file holds no vectors");
      end
      vec_count = vectors.size();

      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (vectors[i]) begin
         if (i > 0) begin
            check_registered();
         end
         parse_vector(vectors[i], n_fields);
         if (n_fields != 30) begin
            stop_run("a vector line has the wrong number of fields");
         end
         apply_decode_flags(in_flags);
         {ctrl_op_lsu_load_i, ctrl_op_mfspr_i, ctrl_op_mul_i} = in_ctrl;
         {decode_immjbr_upper_i, decode_imm16_i} = in_imm;
         // Register values matter only to a jump register
         if (in_flags[6]) begin
            decode_rfb_i = in_rfb_d;
            execute_rfb_i = in_rfb_e;
         end else begin
            decode_rfb_i = $urandom;
            execute_rfb_i = $urandom;
         end
         #5;
         check_combinational();
         @(posedge clk);
         #1;
      end
      check_registered();
      $display("** PASS **");
      $finish;
   end

   initial begin
      wait (vec_count != 0);
      #((vec_count + 20) * 10);
      stop_run("the simulation did not finish in time");
   end

endmodule

/* dv/dx_testdata.txt */
# pv fl flags(alu mul ld st at mf jbr jr jal bc bf bnf rfe wb) rfd rfa rfb opc pc imm rfb_d rfb_e pf il ctrl(ld mf mul) crfd
#  bubble branch target  xflags(alu mul ld st at mf jr jal bc bf bnf rfe wb) xbub valid opc rfd pc jal mis pf il al chk
# Hex except flag groups; chk bit0 compares rfd/pc/jal, bit1 mispredict target and predicted flag
0 0 00000000000000 0 0 0 05 0 0 0 0 0 0 000 0  0 0 0  0000000000000 0 0 05 0 0 0 0 0 0 0 0
1 0 10000000000001 3 1 2 38 100 0 0 0 0 0 000 0  0 0 0  1000000000001 0 1 38 3 100 108 0 0 0 0 1
0 0 00100000000001 4 1 2 21 104 0 0 0 0 0 000 0  0 0 0  1000000000001 0 0 38 3 100 108 0 0 0 0 1
1 0 00100000000001 4 1 2 21 104 0 0 0 0 0 000 0  0 0 0  0010000000001 0 1 21 4 104 10c 0 0 0 0 1
1 0 10000000000001 5 4 2 38 108 0 0 0 0 0 000 0  1 0 0  0000000000000 1 1 05 5 108 110 0 0 0 0 1
1 0 00000000000010 0 0 0 09 10c 0 0 0 0 0 000 0  1 0 0  0000000000010 1 1 05 0 10c 114 0 0 0 0 1
1 0 00000010011000 0 0 0 04 200 10 0 0 1 0 000 0  0 1 240  0000000011000 0 1 04 0 200 208 208 1 0 0 3
1 0 00000010011000 0 0 0 04 300 3fffffc 0 0 0 1 000 0  0 0 0  0000000011000 0 1 04 0 300 308 2f0 0 1 0 3
1 0 00000010100001 9 0 0 01 400 100 0 0 0 0 000 0  0 1 800  0000000100001 0 1 01 9 400 408 0 0 0 0 1
1 0 00000001000000 0 0 9 11 500 0 1234 602 0 0 000 0  1 0 0  0000000000000 1 1 05 0 500 508 0 0 0 0 1
1 0 00000001000000 0 0 9 11 500 0 1234 602 0 0 000 0  0 1 602  0000001000000 0 1 11 0 500 508 0 0 0 1 1
1 0 00000001000000 0 0 9 11 600 0 700 704 0 0 000 0  0 1 704  0000001000000 0 1 11 0 600 608 0 0 0 0 1
1 0 10000000000001 7 1 2 38 700 0 0 0 0 0 000 0  0 0 0  1000000000001 0 1 38 7 700 708 0 0 0 0 1
1 0 00000001000000 0 0 3 11 704 0 800 900 0 0 000 0  0 1 800  0000001000000 0 1 11 0 704 70c 0 0 0 0 1
1 0 01000000000001 8 6 2 38 800 0 0 0 0 0 001 6  1 0 0  0000000000000 1 1 05 8 800 808 0 0 0 0 1
1 0 10000000000001 3 1 2 38 804 0 0 0 0 0 100 2  0 0 0  1000000000001 0 1 38 3 804 80c 0 0 0 0 1
1 0 00011000000000 0 1 2 33 900 0 0 0 0 0 000 0  0 0 0  0001100000000 0 1 33 0 900 908 0 0 0 0 1
1 0 10000000000001 5 1 2 38 904 0 0 0 0 0 000 0  1 0 0  0000000000000 1 1 05 5 904 90c 0 0 0 0 1
1 0 00000000000010 0 0 0 09 a00 0 0 0 0 0 000 0  1 0 0  0000000000010 1 1 05 0 a00 a08 0 0 0 0 1
1 1 00000010000000 0 0 0 00 b00 4 0 0 0 0 000 0  0 0 0  0000000000000 0 1 05 0 b00 b08 0 0 0 0 1
1 0 00000100000001 a 0 0 2d c00 0 0 0 0 0 000 0  0 0 0  0000010000001 0 1 2d a c00 c08 0 0 0 0 1
0 0 10000000000001 1 0 a 38 c04 0 0 0 0 0 000 0  0 0 0  0000010000001 0 0 2d a c00 c08 0 0 0 0 1
1 0 10000000000001 1 0 a 38 c04 0 0 0 0 0 000 0  1 0 0  0000000000000 1 1 05 1 c04 c0c 0 0 0 0 1
0 1 00000000000000 0 0 0 05 0 0 0 0 0 0 000 0  0 0 0  0000000000000 0 0 05 1 c04 c0c 0 0 0 0 1

/* verilog.f */
+incdir+include
hdl/dx_isa_pkg.sv
hdl/dx_pipe_pkg.sv
hdl/dx_hazard_detect.sv
hdl/dx_branch_resolve.sv
hdl/dx_execute_reg.sv
hdl/decode_execute.sv
dv/decode_execute_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the decode to execute testbench with Verilator and run it from the project root
verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
   --top-module decode_execute_tb -o sim_decode_execute \
   && ./obj_dir/sim_decode_execute \
   || { echo "Simulation failed"; exit 1; }
